//--- hdl/daf_pkg.sv
package daf_pkg;

  // sample word layout
  localparam int SAMPLE_W = 16;

  // pot value to amplitude threshold
  localparam int LEVEL_SHIFT = 11;

  // flanger delay line
  localparam int DELAY_DEPTH = 64;
  localparam int DELAY_MIN = 4;
  localparam int DELAY_MAX = 32;
  localparam int ADDR_W = $clog2(DELAY_DEPTH);
  localparam int TAP_W = $clog2(DELAY_MAX + 1);

  // volume gain is vol / 8
  localparam int VOL_SHIFT = 3;

  // fader ramp
  localparam int FADE_STEP_SAMPLES = 16;
  localparam int FADE_MAX = 15;
  localparam int FADE_W = $clog2(FADE_MAX + 1);
  localparam int FADE_SHIFT = 4;
  localparam int STEP_W = $clog2(FADE_STEP_SAMPLES);

  // mixer accumulator, wide enough for vol and fade products
  localparam int MIX_W = 24;

  // one stereo sample word, left channel in the upper half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] left;
    logic signed [SAMPLE_W-1:0] right;
  } stereo_sample_t;

  // user switches and pots, held as levels
  typedef struct packed {
    logic       flanger_en;
    logic       clip_en;
    logic       comp_en;
    logic       fader_en;
    logic [3:0] vol;
    logic [3:0] clip_level;
    logic [3:0] comp_level;
  } effect_ctrl_t;

endpackage

//--- hdl/amp_shaper.sv
`timescale 1ns/1ps

module amp_shaper import daf_pkg::*; (
  input  logic           tb_clk,
  input  logic           rst,
  input  logic           sample_strobe,
  input  stereo_sample_t sample_in,
  input  effect_ctrl_t   ctrl,
  output logic           shaped_strobe,
  output stereo_sample_t shaped_sample
);

  // magnitude needs one extra bit for -32768
  function automatic logic [SAMPLE_W:0] mag_of(input logic signed [SAMPLE_W-1:0] x);
    logic signed [SAMPLE_W:0] xe;
    xe = x;
    return (xe < 0) ? -xe : xe;
  endfunction

  function automatic logic [SAMPLE_W:0] level_th(input logic [3:0] pot);
    return (SAMPLE_W + 1)'(pot) << LEVEL_SHIFT;
  endfunction

  function automatic logic signed [SAMPLE_W-1:0] shape_channel(
    input logic signed [SAMPLE_W-1:0] x,
    input effect_ctrl_t               c
  );
    logic [SAMPLE_W:0]        mag;
    logic [SAMPLE_W:0]        comp_th;
    logic [SAMPLE_W:0]        clip_th;
    logic signed [SAMPLE_W:0] res;
    mag = mag_of(x);
    comp_th = level_th(c.comp_level);
    clip_th = level_th(c.clip_level);
    // halve the part above the comp knee
    if (c.comp_en && (mag > comp_th)) begin
      mag = comp_th + ((mag - comp_th) >> 1);
    end
    if (c.clip_en && (mag > clip_th)) begin
      mag = clip_th;
    end
    // restore the sign
    res = x[SAMPLE_W-1] ? -$signed(mag) : $signed(mag);
    return res[SAMPLE_W-1:0];
  endfunction

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      shaped_strobe <= 1'b0;
      shaped_sample <= '0;
    end else begin
      shaped_strobe <= sample_strobe;
      if (sample_strobe) begin
        shaped_sample.left <= shape_channel(sample_in.left, ctrl);
        shaped_sample.right <= shape_channel(sample_in.right, ctrl);
      end
    end
  end

  // clip threshold taken from the pot setting seen with the input
  clip_bound_a: assert property (@(posedge tb_clk) disable iff (rst)
    (sample_strobe && ctrl.clip_en) |=>
      (mag_of(shaped_sample.left) <= level_th($past(ctrl.clip_level))) &&
      (mag_of(shaped_sample.right) <= level_th($past(ctrl.clip_level))))
    else $error("shaped sample exceeds clip threshold");

endmodule

//--- hdl/flanger_delay.sv
`timescale 1ns/1ps

module flanger_delay import daf_pkg::*; (
  input  logic           tb_clk,
  input  logic           rst,
  input  logic           sample_strobe,
  input  stereo_sample_t sample_in,
  input  logic           mem_clr,
  output logic           delayed_strobe,
  output stereo_sample_t delayed_sample
);

  stereo_sample_t         mem [DELAY_DEPTH];
  logic [DELAY_DEPTH-1:0] valid;
  logic [ADDR_W-1:0]      wr_ptr;
  logic [ADDR_W-1:0]      rd_addr;
  logic [TAP_W-1:0]       tap;
  logic                   dir_up;

  // tap entries behind the slot being written now
  assign rd_addr = wr_ptr - ADDR_W'(tap);

  always_ff @(posedge tb_clk) begin
    if (sample_strobe) begin
      mem[wr_ptr] <= sample_in;
    end
  end

  // write pointer, valid bits and read port
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      valid <= '0;
      wr_ptr <= '0;
      delayed_strobe <= 1'b0;
      delayed_sample <= '0;
    end else if (mem_clr) begin
      valid <= '0;
      wr_ptr <= '0;
      delayed_strobe <= 1'b0;
    end else begin
      delayed_strobe <= sample_strobe;
      if (sample_strobe) begin
        // tap is never zero, so the read never hits the slot being written
        delayed_sample <= valid[rd_addr] ? mem[rd_addr] : '0;
        valid[wr_ptr] <= 1'b1;
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // triangle sweep of the tap between min and max
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      tap <= TAP_W'(DELAY_MIN);
      dir_up <= 1'b1;
    end else if (sample_strobe) begin
      if (dir_up) begin
        tap <= tap + 1'b1;
        if (tap == TAP_W'(DELAY_MAX - 1)) begin
          dir_up <= 1'b0;
        end
      end else begin
        tap <= tap - 1'b1;
        if (tap == TAP_W'(DELAY_MIN + 1)) begin
          dir_up <= 1'b1;
        end
      end
    end
  end

  tap_range_a: assert property (@(posedge tb_clk) disable iff (rst)
    sample_strobe |=> (tap >= TAP_W'(DELAY_MIN)) && (tap <= TAP_W'(DELAY_MAX)))
    else $error("flanger tap left its sweep range");

  // clear and sample on the same edge would drop the sample
  clr_apart_a: assert property (@(posedge tb_clk) disable iff (rst)
    mem_clr |-> !sample_strobe)
    else $error("mem_clr coincides with sample_strobe");

endmodule

//--- hdl/effect_mixer.sv
`timescale 1ns/1ps

module effect_mixer import daf_pkg::*; (
  input  logic           tb_clk,
  input  logic           rst,
  input  logic           shaped_strobe,
  input  stereo_sample_t shaped_sample,
  input  logic           delayed_strobe,
  input  stereo_sample_t delayed_sample,
  input  effect_ctrl_t   ctrl,
  output logic           out_strobe,
  output stereo_sample_t sample_out
);

  logic              both_valid;
  logic [FADE_W-1:0] fade_level;
  logic [STEP_W-1:0] step_cnt;

  assign both_valid = shaped_strobe && delayed_strobe;

  function automatic logic signed [SAMPLE_W-1:0] mix_channel(
    input logic signed [SAMPLE_W-1:0] dry,
    input logic signed [SAMPLE_W-1:0] dly,
    input effect_ctrl_t               c,
    input logic [FADE_W-1:0]          level
  );
    logic signed [MIX_W-1:0] acc;
    acc = dry;
    if (c.flanger_en) begin
      acc = (acc + dly) >>> 1;
    end
    acc = (acc * $signed({1'b0, c.vol})) >>> VOL_SHIFT;
    if (c.fader_en) begin
      acc = (acc * $signed({1'b0, level})) >>> FADE_SHIFT;
    end
    // saturate when the upper bits are not all sign copies
    if (acc[MIX_W-1:SAMPLE_W-1] != {(MIX_W - SAMPLE_W + 1){acc[MIX_W-1]}}) begin
      return {acc[MIX_W-1], {(SAMPLE_W - 1){~acc[MIX_W-1]}}};
    end
    return acc[SAMPLE_W-1:0];
  endfunction

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      out_strobe <= 1'b0;
      sample_out <= '0;
    end else begin
      out_strobe <= both_valid;
      if (both_valid) begin
        sample_out.left <= mix_channel(shaped_sample.left, delayed_sample.left,
                                       ctrl, fade_level);
        sample_out.right <= mix_channel(shaped_sample.right, delayed_sample.right,
                                        ctrl, fade_level);
      end
    end
  end

  // fade level drops one step every FADE_STEP_SAMPLES outputs
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      fade_level <= FADE_W'(FADE_MAX);
      step_cnt <= '0;
    end else if (!ctrl.fader_en) begin
      fade_level <= FADE_W'(FADE_MAX);
      step_cnt <= '0;
    end else if (both_valid) begin
      if (step_cnt == STEP_W'(FADE_STEP_SAMPLES - 1)) begin
        step_cnt <= '0;
        if (fade_level != '0) begin
          fade_level <= fade_level - 1'b1;
        end
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  // both branches have one cycle of latency
  branch_align_a: assert property (@(posedge tb_clk) disable iff (rst)
    shaped_strobe == delayed_strobe)
    else $error("shaper and flanger strobes are out of step");

endmodule

//--- hdl/daf_aff.sv
`timescale 1ns/1ps

module daf_aff import daf_pkg::*; (
  input  logic           tb_clk,
  input  logic           rst,
  input  logic           sample_strobe,
  input  stereo_sample_t sample_in,
  input  effect_ctrl_t   ctrl,
  input  logic           mem_clr,
  output logic           out_strobe,
  output stereo_sample_t sample_out
);

  logic           shaped_strobe;
  stereo_sample_t shaped_sample;
  logic           delayed_strobe;
  stereo_sample_t delayed_sample;

  // compression and clipping branch
  amp_shaper i_amp_shaper (
    .tb_clk        (tb_clk),
    .rst           (rst),
    .sample_strobe (sample_strobe),
    .sample_in     (sample_in),
    .ctrl          (ctrl),
    .shaped_strobe (shaped_strobe),
    .shaped_sample (shaped_sample)
  );

  // delay branch works on the raw input
  flanger_delay i_flanger_delay (
    .tb_clk         (tb_clk),
    .rst            (rst),
    .sample_strobe  (sample_strobe),
    .sample_in      (sample_in),
    .mem_clr        (mem_clr),
    .delayed_strobe (delayed_strobe),
    .delayed_sample (delayed_sample)
  );

  effect_mixer i_effect_mixer (
    .tb_clk         (tb_clk),
    .rst            (rst),
    .shaped_strobe  (shaped_strobe),
    .shaped_sample  (shaped_sample),
    .delayed_strobe (delayed_strobe),
    .delayed_sample (delayed_sample),
    .ctrl           (ctrl),
    .out_strobe     (out_strobe),
    .sample_out     (sample_out)
  );

endmodule

//--- verification/tb_daf_aff.sv
`timescale 1ns/1ps

module tb_daf_aff import daf_pkg::*; ();

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 10;
  localparam int SPACING = 8;
  localparam int N_BYPASS = 24;
  localparam int N_SHAPE = 48;
  localparam int N_FLANGE = 80;
  localparam int N_VOL = 12;
  localparam int N_FADE = 17 * FADE_STEP_SAMPLES + 8;
  localparam int TOTAL_SAMPLES = N_BYPASS + N_SHAPE + N_FLANGE + N_VOL + N_FADE;
  localparam int WATCHDOG_NS = 2 * TOTAL_SAMPLES * SPACING * CLK_PERIOD_NS;

  logic           tb_clk;
  logic           rst;
  logic           sample_strobe;
  stereo_sample_t sample_in;
  effect_ctrl_t   ctrl;
  logic           mem_clr;
  logic           out_strobe;
  stereo_sample_t sample_out;

  // reference model state
  stereo_sample_t hist[$];
  stereo_sample_t exp_q[$];
  int             pending;
  int             tap_m;
  logic           up_m;
  int             fade_m;
  int             step_m;

  int             seed;
  string          cur_test;
  int             err_count;
  int             test_err_start;
  int             tests_passed;
  int             tests_failed;
  int             out_checks;
  logic           quiet_check;
  stereo_sample_t head;
  stereo_sample_t last_out;

  daf_aff i_dut (
    .tb_clk        (tb_clk),
    .rst           (rst),
    .sample_strobe (sample_strobe),
    .sample_in     (sample_in),
    .ctrl          (ctrl),
    .mem_clr       (mem_clr),
    .out_strobe    (out_strobe),
    .sample_out    (sample_out)
  );

  initial tb_clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) tb_clk = ~tb_clk;

  // compress the excess over the knee, then clamp the magnitude
  function automatic int shape_ref(input int x, input effect_ctrl_t c);
    int mag;
    int knee;
    int limit;
    mag = (x < 0) ? -x : x;
    knee = int'(c.comp_level) << LEVEL_SHIFT;
    limit = int'(c.clip_level) << LEVEL_SHIFT;
    if (c.comp_en && mag > knee) begin
      mag = knee + (mag - knee) / 2;
    end
    if (c.clip_en && mag > limit) begin
      mag = limit;
    end
    return (x < 0) ? -mag : mag;
  endfunction

  function automatic int mix_ref(input int dry, input int dly, input effect_ctrl_t c,
                                 input int level);
    int v;
    v = c.flanger_en ? ((dry + dly) >>> 1) : dry;
    v = (v * int'(c.vol)) >>> VOL_SHIFT;
    if (c.fader_en) begin
      v = (v * level) >>> 4;
    end
    if (v > 32767) begin
      v = 32767;
    end else if (v < -32768) begin
      v = -32768;
    end
    return v;
  endfunction

  function automatic effect_ctrl_t ctrl_of(input logic fl, input logic cl, input logic co,
                                           input logic fa, input int vol, input int clip_lvl,
                                           input int comp_lvl);
    effect_ctrl_t c;
    c.flanger_en = fl;
    c.clip_en = cl;
    c.comp_en = co;
    c.fader_en = fa;
    c.vol = 4'(vol);
    c.clip_level = 4'(clip_lvl);
    c.comp_level = 4'(comp_lvl);
    return c;
  endfunction

  task automatic set_ctrl(input effect_ctrl_t c);
    @(posedge tb_clk);
    ctrl <= c;
  endtask

  task automatic clear_delay();
    @(posedge tb_clk);
    mem_clr <= 1'b1;
    @(posedge tb_clk);
    mem_clr <= 1'b0;
    hist.delete();
  endtask

  // model the sample, queue the expected output, then drive it
  task automatic send_sample(input stereo_sample_t s);
    stereo_sample_t shaped;
    stereo_sample_t dly;
    stereo_sample_t expv;
    int             level;
    @(posedge tb_clk);
    shaped.left = SAMPLE_W'(shape_ref(s.left, ctrl));
    shaped.right = SAMPLE_W'(shape_ref(s.right, ctrl));
    dly = (hist.size() >= tap_m) ? hist[hist.size() - tap_m] : '0;
    hist.push_back(s);
    if (hist.size() > DELAY_DEPTH) begin
      hist.delete(0);
    end
    if (up_m) begin
      tap_m++;
      up_m = (tap_m != DELAY_MAX);
    end else begin
      tap_m--;
      up_m = (tap_m == DELAY_MIN);
    end
    level = ctrl.fader_en ? fade_m : FADE_MAX;
    if (ctrl.fader_en) begin
      step_m++;
      if (step_m == FADE_STEP_SAMPLES) begin
        step_m = 0;
        fade_m = (fade_m > 0) ? fade_m - 1 : 0;
      end
    end else begin
      fade_m = FADE_MAX;
      step_m = 0;
    end
    expv.left = SAMPLE_W'(mix_ref(shaped.left, dly.left, ctrl, level));
    expv.right = SAMPLE_W'(mix_ref(shaped.right, dly.right, ctrl, level));
    exp_q.push_back(expv);
    pending++;
    sample_strobe <= 1'b1;
    sample_in <= s;
    @(posedge tb_clk);
    sample_strobe <= 1'b0;
    repeat (SPACING - 2) @(posedge tb_clk);
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      send_sample(stereo_sample_t'($random(seed)));
    end
  endtask

  // full scale, zero and near-knee values
  task automatic send_extremes();
    send_sample({16'sh7fff, 16'sh8000});
    send_sample({16'sh8000, 16'sh7fff});
    send_sample({16'sh0000, 16'shffff});
    send_sample({16'sh4000, 16'shbfff});
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = err_count;
  endtask

  task automatic report_test();
    if (err_count == test_err_start) begin
      tests_passed++;
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, err_count - test_err_start);
    end
  endtask

  // outputs are sampled half a cycle after the edge that set them
  always @(negedge tb_clk) begin
    if (quiet_check) begin
      quiet_a: assert (!out_strobe && sample_out == '0) else begin
        $display("CHECK FAILED %s expected %h actual %h", cur_test, 33'h0,
                 {out_strobe, sample_out});
        err_count++;
      end
    end
    if (!rst && out_strobe && exp_q.size() > 0) begin
      head = exp_q.pop_front();
      pending--;
      last_out = sample_out;
      out_checks++;
      out_match_a: assert (sample_out == head) else begin
        $display("CHECK FAILED %s expected %h actual %h", cur_test, head, sample_out);
        err_count++;
      end
    end
  end

  strobe_latency_a: assert property (@(posedge tb_clk) disable iff (rst)
    sample_strobe |-> ##2 out_strobe)
    else begin
      $display("out_strobe did not follow sample_strobe by 2 cycles in %s", cur_test);
      err_count++;
    end

  // every cycle of out_strobe must consume one outstanding sample
  no_spurious_out_a: assert property (@(negedge tb_clk) disable iff (rst)
    out_strobe |-> (pending > 0))
    else begin
      $display("out_strobe was high with no sample outstanding in %s", cur_test);
      err_count++;
    end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the DUT stopped producing outputs", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed = 16215;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    out_checks = 0;
    pending = 0;
    tap_m = DELAY_MIN;
    up_m = 1'b1;
    fade_m = FADE_MAX;
    step_m = 0;
    last_out = '0;
    quiet_check = 1'b1;
    rst = 1'b1;
    sample_strobe = 1'b0;
    sample_in = '0;
    ctrl = '0;
    mem_clr = 1'b0;

    start_test("reset_quiet");
    repeat (RESET_CYCLES) @(posedge tb_clk);
    rst <= 1'b0;
    repeat (4) @(posedge tb_clk);
    quiet_check = 1'b0;
    report_test();

    start_test("bypass");
    set_ctrl(ctrl_of(0, 0, 0, 0, 8, 0, 0));
    send_extremes();
    send_random(N_BYPASS - 4);
    report_test();

    // second setting puts the clip level below the compressed peaks
    start_test("shaping");
    set_ctrl(ctrl_of(0, 1, 1, 0, 8, 12, 8));
    send_extremes();
    send_random(N_SHAPE / 2 - 4);
    set_ctrl(ctrl_of(0, 1, 1, 0, 8, 6, 4));
    send_extremes();
    send_random(N_SHAPE / 2 - 4);
    report_test();

    // 80 samples cover a full sweep up and back down
    start_test("flanger_clear");
    set_ctrl(ctrl_of(1, 0, 0, 0, 8, 0, 0));
    clear_delay();
    send_random(N_FLANGE);
    report_test();

    start_test("volume_saturation");
    set_ctrl(ctrl_of(0, 0, 0, 0, 15, 0, 0));
    send_extremes();
    send_random(N_VOL - 4);
    report_test();

    start_test("fader_ramp");
    set_ctrl(ctrl_of(0, 0, 0, 1, 8, 0, 0));
    send_random(N_FADE - 8);
    fade_zero_a: assert (last_out == '0) else begin
      $display("CHECK FAILED %s expected %h actual %h", cur_test, 32'h0, last_out);
      err_count++;
    end
    set_ctrl(ctrl_of(0, 0, 0, 0, 8, 0, 0));
    send_random(4);
    // ramp starts again from full level
    set_ctrl(ctrl_of(0, 0, 0, 1, 8, 0, 0));
    send_random(4);
    report_test();

    $display("tests passed %0d, tests failed %0d, output checks %0d, errors %0d",
             tests_passed, tests_failed, out_checks, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
hdl/daf_pkg.sv
hdl/amp_shaper.sv
hdl/flanger_delay.sv
hdl/effect_mixer.sv
hdl/daf_aff.sv
verification/tb_daf_aff.sv

//--- Makefile
# Verilator build and run for the audio effects testbench

VERILATOR ?= verilator
TOP       ?= tb_daf_aff
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
